// File: subsys_cfg.svh
/*
 * subsystem configuration macros: bus widths, power domains,
 * switch-cell latency, counter limit and peripheral base addresses
 */
`ifndef SUBSYS_CFG_SVH
`define SUBSYS_CFG_SVH

// register bus
`define ADDR_W 32
`define DATA_W 32

// power-switch controller
`define NUM_DOMAINS 4
`define SWITCH_ACK_LATENCY 15

// event counter wrap limit out of reset
`define CNT_MAX_RESET 2048

// interrupt sources
`define NUM_INT 2

// address map, one window of 2**WINDOW_W bytes per peripheral
`define PWR_BASE 32'h0000_0000
`define CNT_BASE 32'h0000_0100
`define INTR_BASE 32'h0000_0200
`define WINDOW_W 8

`endif

// File: reg_bus_pkg.sv
/*
 * register bus types: address, data, window offset and target select
 */
`include "subsys_cfg.svh"

package reg_bus_pkg;

  typedef logic [`ADDR_W-1:0] reg_addr_t;
  typedef logic [`DATA_W-1:0] reg_data_t;

  // byte offset inside one peripheral window
  typedef logic [`WINDOW_W-1:0] reg_offs_t;

  // decoded target of an access
  typedef enum logic [1:0] {
    SEL_PWR,
    SEL_CNT,
    SEL_INTR,
    SEL_NONE
  } periph_sel_e;

endpackage

// File: periph_pkg.sv
/*
 * peripheral types: register offsets, domain and counter vectors,
 * interrupt bit positions and the power-switch state enum
 */
`include "subsys_cfg.svh"

package periph_pkg;

  import reg_bus_pkg::*;

  typedef logic [`NUM_DOMAINS-1:0] domain_mask_t;
  typedef logic [`DATA_W-1:0] cnt_t;
  typedef logic [`NUM_INT-1:0] intr_vec_t;

  // interrupt source positions in intr_vec_t
  localparam int unsigned INTR_PWR_DONE_BIT = 0;
  localparam int unsigned INTR_CNT_WRAP_BIT = 1;

  // busy flag position in PWR_STATUS
  localparam int unsigned PWR_BUSY_BIT = 8;

  typedef enum logic {
    PWR_IDLE,
    PWR_WAIT_ACK
  } pwr_state_e;

  // power-switch controller window
  localparam reg_offs_t PWR_CTRL_OFFS = 8'h00;
  localparam reg_offs_t PWR_STATUS_OFFS = 8'h04;

  // event counter window
  localparam reg_offs_t CNT_MAX_OFFS = 8'h00;
  localparam reg_offs_t CNT_VAL_OFFS = 8'h04;

  // interrupt controller window
  localparam reg_offs_t INTR_PENDING_OFFS = 8'h00;
  localparam reg_offs_t INTR_ENABLE_OFFS = 8'h04;

endpackage

// File: periph_reg_if.sv
/*
 * one register access from the decoder to a peripheral
 */
`timescale 1ns/1ps

interface periph_reg_if
  import reg_bus_pkg::*;
();

  // request, driven by the decoder
  logic      valid;
  logic      write;
  reg_offs_t offs;
  reg_data_t wdata;

  // same-cycle response from the peripheral
  reg_data_t rdata;
  logic      error;

  modport host (
    output valid,
    output write,
    output offs,
    output wdata,
    input  rdata,
    input  error
  );

  modport dev (
    input  valid,
    input  write,
    input  offs,
    input  wdata,
    output rdata,
    output error
  );

endinterface

// File: periph_bus_decode.sv
/*
 * address window decode, request routing and response mux
 */
`timescale 1ns/1ps
`include "subsys_cfg.svh"

module periph_bus_decode
  import reg_bus_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      reg_valid_i,
  input  logic      reg_write_i,
  input  reg_addr_t reg_addr_i,
  input  reg_data_t reg_wdata_i,
  output reg_data_t reg_rdata_o,
  output logic      reg_error_o,
  periph_reg_if.host pwr_if,
  periph_reg_if.host cnt_if,
  periph_reg_if.host intr_if
);

  localparam int unsigned PAGE_W = `ADDR_W - `WINDOW_W;
  localparam reg_addr_t PWR_BASE_ADDR = `PWR_BASE;
  localparam reg_addr_t CNT_BASE_ADDR = `CNT_BASE;
  localparam reg_addr_t INTR_BASE_ADDR = `INTR_BASE;

  logic [PAGE_W-1:0] page;
  periph_sel_e       sel;

  // address bits above the window pick the peripheral
  assign page = reg_addr_i[`ADDR_W-1:`WINDOW_W];

  always_comb begin
    if (page == PWR_BASE_ADDR[`ADDR_W-1:`WINDOW_W]) begin
      sel = SEL_PWR;
    end else if (page == CNT_BASE_ADDR[`ADDR_W-1:`WINDOW_W]) begin
      sel = SEL_CNT;
    end else if (page == INTR_BASE_ADDR[`ADDR_W-1:`WINDOW_W]) begin
      sel = SEL_INTR;
    end else begin
      sel = SEL_NONE;
    end
  end

  // offset, direction and data fan out to every window
  assign pwr_if.write  = reg_write_i;
  assign pwr_if.offs   = reg_addr_i[`WINDOW_W-1:0];
  assign pwr_if.wdata  = reg_wdata_i;
  assign cnt_if.write  = reg_write_i;
  assign cnt_if.offs   = reg_addr_i[`WINDOW_W-1:0];
  assign cnt_if.wdata  = reg_wdata_i;
  assign intr_if.write = reg_write_i;
  assign intr_if.offs  = reg_addr_i[`WINDOW_W-1:0];
  assign intr_if.wdata = reg_wdata_i;

  // only the selected window sees valid
  assign pwr_if.valid  = reg_valid_i && (sel == SEL_PWR);
  assign cnt_if.valid  = reg_valid_i && (sel == SEL_CNT);
  assign intr_if.valid = reg_valid_i && (sel == SEL_INTR);

  always_comb begin
    case (sel)
      SEL_PWR: begin
        reg_rdata_o = pwr_if.rdata;
        reg_error_o = pwr_if.error;
      end
      SEL_CNT: begin
        reg_rdata_o = cnt_if.rdata;
        reg_error_o = cnt_if.error;
      end
      SEL_INTR: begin
        reg_rdata_o = intr_if.rdata;
        reg_error_o = intr_if.error;
      end
      default: begin
        // hole in the address map
        reg_rdata_o = '0;
        reg_error_o = reg_valid_i;
      end
    endcase
  end

endmodule

// File: pwr_switch_ctrl.sv
/*
 * power-domain switch control with switch-cell acknowledge model
 * and isolation derived from switch and acknowledge
 */
`timescale 1ns/1ps
`include "subsys_cfg.svh"

module pwr_switch_ctrl
  import reg_bus_pkg::*;
  import periph_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  periph_reg_if.dev    bus_if,
  output domain_mask_t pwr_switch_n_o,
  output domain_mask_t pwr_iso_n_o,
  output logic         pwr_done_o
);

  pwr_state_e   state_q;
  pwr_state_e   state_d;
  domain_mask_t switch_q;
  domain_mask_t ack_n;
  domain_mask_t ack_chain_q [`SWITCH_ACK_LATENCY];
  logic         ctrl_we;
  logic         ack_match;
  reg_data_t    status;

  // stands in for the switch cells, ack follows switch after the latency
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `SWITCH_ACK_LATENCY; i++) begin
        ack_chain_q[i] <= '0;
      end
    end else begin
      ack_chain_q[0] <= switch_q;
      for (int i = 1; i < `SWITCH_ACK_LATENCY; i++) begin
        ack_chain_q[i] <= ack_chain_q[i-1];
      end
    end
  end

  assign ack_n     = ack_chain_q[`SWITCH_ACK_LATENCY-1];
  assign ack_match = (ack_n == switch_q);

  always_comb begin
    state_d = state_q;
    case (state_q)
      PWR_IDLE: begin
        if (ctrl_we) begin
          state_d = PWR_WAIT_ACK;
        end
      end
      PWR_WAIT_ACK: begin
        if (ack_match) begin
          state_d = PWR_IDLE;
        end
      end
      default: state_d = PWR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= PWR_IDLE;
      switch_q <= '0;
    end else begin
      state_q <= state_d;
      if (ctrl_we) begin
        switch_q <= bus_if.wdata[`NUM_DOMAINS-1:0];
      end
    end
  end

  // one-cycle pulse, state is back to idle at the next edge
  assign pwr_done_o = (state_q == PWR_WAIT_ACK) && ack_match;

  // isolation released only for domains requested on and acknowledged on
  assign pwr_iso_n_o    = ~switch_q & ~ack_n;
  assign pwr_switch_n_o = switch_q;

  always_comb begin
    status = '0;
    status[`NUM_DOMAINS-1:0] = ~ack_n;
    status[PWR_BUSY_BIT] = (state_q == PWR_WAIT_ACK);
  end

  always_comb begin
    bus_if.rdata = '0;
    bus_if.error = 1'b0;
    ctrl_we      = 1'b0;
    if (bus_if.valid) begin
      case (bus_if.offs)
        PWR_CTRL_OFFS: begin
          if (!bus_if.write) begin
            bus_if.rdata = reg_data_t'(switch_q);
          end else if (state_q == PWR_IDLE) begin
            ctrl_we = 1'b1;
          end else begin
            // a switch sequence is still in flight
            bus_if.error = 1'b1;
          end
        end
        PWR_STATUS_OFFS: begin
          if (bus_if.write) begin
            bus_if.error = 1'b1;
          end else begin
            bus_if.rdata = status;
          end
        end
        default: bus_if.error = 1'b1;
      endcase
    end
  end

endmodule

// File: gpio_event_cnt.sv
/*
 * gpio rising-edge counter with programmable wrap limit and toggling output
 */
`timescale 1ns/1ps
`include "subsys_cfg.svh"

module gpio_event_cnt
  import reg_bus_pkg::*;
  import periph_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      gpio_i,
  periph_reg_if.dev bus_if,
  output logic      gpio_o,
  output logic      cnt_wrap_o
);

  logic [1:0] sync_q;
  logic       prev_q;
  logic       rise;
  cnt_t       cnt_q;
  cnt_t       max_q;
  cnt_t       cnt_inc;
  logic       max_we;

  // two-flop synchronizer, then edge detect
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync_q <= '0;
      prev_q <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], gpio_i};
      prev_q <= sync_q[1];
    end
  end

  assign rise    = sync_q[1] && !prev_q;
  assign cnt_inc = cnt_q + cnt_t'(1);

  // a limit write restarts the count and masks a coincident edge
  assign cnt_wrap_o = rise && !max_we && (cnt_inc == max_q);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      max_q  <= cnt_t'(`CNT_MAX_RESET);
      gpio_o <= 1'b0;
    end else if (max_we) begin
      cnt_q <= '0;
      max_q <= bus_if.wdata;
    end else if (cnt_wrap_o) begin
      cnt_q  <= '0;
      gpio_o <= !gpio_o;
    end else if (rise) begin
      cnt_q <= cnt_inc;
    end
  end

  always_comb begin
    bus_if.rdata = '0;
    bus_if.error = 1'b0;
    max_we       = 1'b0;
    if (bus_if.valid) begin
      case (bus_if.offs)
        CNT_MAX_OFFS: begin
          if (!bus_if.write) begin
            bus_if.rdata = max_q;
          end else if (bus_if.wdata == '0) begin
            // zero limit would never wrap
            bus_if.error = 1'b1;
          end else begin
            max_we = 1'b1;
          end
        end
        CNT_VAL_OFFS: begin
          if (bus_if.write) begin
            bus_if.error = 1'b1;
          end else begin
            bus_if.rdata = cnt_q;
          end
        end
        default: bus_if.error = 1'b1;
      endcase
    end
  end

endmodule

// File: intr_ctrl.sv
/*
 * pending and enable registers forming the masked interrupt vector
 */
`timescale 1ns/1ps
`include "subsys_cfg.svh"

module intr_ctrl
  import reg_bus_pkg::*;
  import periph_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      pwr_done_i,
  input  logic      cnt_wrap_i,
  periph_reg_if.dev bus_if,
  output intr_vec_t intr_vector_o
);

  intr_vec_t pending_q;
  intr_vec_t enable_q;
  intr_vec_t events;
  intr_vec_t clr;
  logic      enable_we;

  always_comb begin
    events = '0;
    events[INTR_PWR_DONE_BIT] = pwr_done_i;
    events[INTR_CNT_WRAP_BIT] = cnt_wrap_i;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      // a new event beats a clear in the same cycle
      pending_q <= (pending_q & ~clr) | events;
      if (enable_we) begin
        enable_q <= bus_if.wdata[`NUM_INT-1:0];
      end
    end
  end

  assign intr_vector_o = pending_q & enable_q;

  always_comb begin
    bus_if.rdata = '0;
    bus_if.error = 1'b0;
    clr          = '0;
    enable_we    = 1'b0;
    if (bus_if.valid) begin
      case (bus_if.offs)
        INTR_PENDING_OFFS: begin
          if (bus_if.write) begin
            clr = bus_if.wdata[`NUM_INT-1:0];
          end else begin
            bus_if.rdata = reg_data_t'(pending_q);
          end
        end
        INTR_ENABLE_OFFS: begin
          if (bus_if.write) begin
            enable_we = 1'b1;
          end else begin
            bus_if.rdata = reg_data_t'(enable_q);
          end
        end
        default: bus_if.error = 1'b1;
      endcase
    end
  end

endmodule

// File: ext_periph_subsys.sv
/*
 * external peripheral subsystem top: decoder, power switch,
 * event counter and interrupt controller
 */
`timescale 1ns/1ps

module ext_periph_subsys
  import reg_bus_pkg::*;
  import periph_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         reg_valid_i,
  input  logic         reg_write_i,
  input  reg_addr_t    reg_addr_i,
  input  reg_data_t    reg_wdata_i,
  output reg_data_t    reg_rdata_o,
  output logic         reg_error_o,
  input  logic         gpio_i,
  output logic         gpio_o,
  output domain_mask_t pwr_switch_n_o,
  output domain_mask_t pwr_iso_n_o,
  output intr_vec_t    intr_vector_o
);

  logic pwr_done;
  logic cnt_wrap;

  periph_reg_if pwr_if ();
  periph_reg_if cnt_if ();
  periph_reg_if intr_if ();

  periph_bus_decode periph_bus_decode_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_valid_i (reg_valid_i),
    .reg_write_i (reg_write_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .reg_error_o (reg_error_o),
    .pwr_if      (pwr_if),
    .cnt_if      (cnt_if),
    .intr_if     (intr_if)
  );

  pwr_switch_ctrl pwr_switch_ctrl_i (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .bus_if         (pwr_if),
    .pwr_switch_n_o (pwr_switch_n_o),
    .pwr_iso_n_o    (pwr_iso_n_o),
    .pwr_done_o     (pwr_done)
  );

  gpio_event_cnt gpio_event_cnt_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .gpio_i     (gpio_i),
    .bus_if     (cnt_if),
    .gpio_o     (gpio_o),
    .cnt_wrap_o (cnt_wrap)
  );

  // both event pulses end up in the interrupt vector
  intr_ctrl intr_ctrl_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .pwr_done_i    (pwr_done),
    .cnt_wrap_i    (cnt_wrap),
    .bus_if        (intr_if),
    .intr_vector_o (intr_vector_o)
  );

endmodule

// File: tb_clk_gen.sv
/*
 * testbench clock (20 ns period) and active-low reset source
 */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // reset low for 16 rising edges, released just after an edge
  initial begin
    rst_n_o = 1'b0;
    repeat (16) @(posedge clk_o);
    #2;
    rst_n_o = 1'b1;
  end

endmodule

// File: ext_periph_properties.sv
/*
 * concurrent checks on the subsystem top for isolation, bus error and interrupt vector
 */
`timescale 1ns/1ps
`include "subsys_cfg.svh"

module ext_periph_properties
  import periph_pkg::*;
(
  input logic         clk_i,
  input logic         rst_n_i,
  input logic         reg_valid_i,
  input logic         reg_error_i,
  input domain_mask_t pwr_switch_n_i,
  input domain_mask_t pwr_iso_n_i,
  input logic         pwr_done_i,
  input logic         cnt_wrap_i,
  input intr_vec_t    pending_i,
  input intr_vec_t    intr_vector_i
);

  intr_vec_t events;

  always_comb begin
    events = '0;
    events[INTR_PWR_DONE_BIT] = pwr_done_i;
    events[INTR_CNT_WRAP_BIT] = cnt_wrap_i;
  end

  // a domain leaves isolation only while its switch is on now and a full latency ago
  iso_needs_switch_on: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (pwr_iso_n_i & (pwr_switch_n_i | $past(pwr_switch_n_i, `SWITCH_ACK_LATENCY))) == '0
  ) else $error("isolation released on a switched-off domain");

  // no error without a request
  error_needs_valid: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    reg_error_i |-> reg_valid_i
  ) else $error("bus error raised without valid");

  // a vector bit needs a pending source that was held or pulsed a cycle before
  vector_within_pending: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (intr_vector_i & ~(pending_i & ($past(pending_i) | $past(events)))) == '0
  ) else $error("interrupt vector bit set without pending source");

endmodule

// File: tb_ext_periph_subsys.sv
/*
 * testbench for the peripheral subsystem with register table, power switching,
 * gpio event counting and interrupt masking
 */
`timescale 1ns/1ps
`include "subsys_cfg.svh"

module tb_ext_periph_subsys
  import reg_bus_pkg::*;
  import periph_pkg::*;
();

  localparam reg_addr_t PWR_CTRL_A     = `PWR_BASE + 32'(PWR_CTRL_OFFS);
  localparam reg_addr_t PWR_STATUS_A   = `PWR_BASE + 32'(PWR_STATUS_OFFS);
  localparam reg_addr_t CNT_MAX_A      = `CNT_BASE + 32'(CNT_MAX_OFFS);
  localparam reg_addr_t CNT_VAL_A      = `CNT_BASE + 32'(CNT_VAL_OFFS);
  localparam reg_addr_t INTR_PENDING_A = `INTR_BASE + 32'(INTR_PENDING_OFFS);
  localparam reg_addr_t INTR_ENABLE_A  = `INTR_BASE + 32'(INTR_ENABLE_OFFS);
  // beyond the three windows
  localparam reg_addr_t HOLE_A         = 32'h0000_0300;

  typedef struct packed {
    logic      write;
    reg_addr_t addr;
    reg_data_t wdata;
    reg_data_t exp_rdata;
    logic      exp_error;
  } access_t;

  logic         clk;
  logic         rst_n;
  logic         reg_valid;
  logic         reg_write;
  reg_addr_t    reg_addr;
  reg_data_t    reg_wdata;
  reg_data_t    reg_rdata;
  logic         reg_error;
  logic         gpio_in;
  logic         gpio_out;
  domain_mask_t pwr_switch_n;
  domain_mask_t pwr_iso_n;
  intr_vec_t    intr_vector;

  access_t      table_q [$];
  intr_vec_t    exp_pending;
  logic [23:0]  lfsr_q;
  int           err_cnt;
  int           check_cnt;

  tb_clk_gen clk_gen_i (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  ext_periph_subsys DUT (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .reg_valid_i    (reg_valid),
    .reg_write_i    (reg_write),
    .reg_addr_i     (reg_addr),
    .reg_wdata_i    (reg_wdata),
    .reg_rdata_o    (reg_rdata),
    .reg_error_o    (reg_error),
    .gpio_i         (gpio_in),
    .gpio_o         (gpio_out),
    .pwr_switch_n_o (pwr_switch_n),
    .pwr_iso_n_o    (pwr_iso_n),
    .intr_vector_o  (intr_vector)
  );

  bind ext_periph_subsys ext_periph_properties props_i (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .reg_valid_i    (reg_valid_i),
    .reg_error_i    (reg_error_o),
    .pwr_switch_n_i (pwr_switch_n_o),
    .pwr_iso_n_i    (pwr_iso_n_o),
    .pwr_done_i     (pwr_done),
    .cnt_wrap_i     (cnt_wrap),
    .pending_i      (intr_ctrl_i.pending_q),
    .intr_vector_i  (intr_vector_o)
  );

  // fibonacci lfsr with taps 24 23 22 17
  function automatic logic [23:0] lfsr_step(input logic [23:0] s);
    logic fb;
    fb = s[23] ^ s[22] ^ s[21] ^ s[16];
    return {s[22:0], fb};
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = (v << 1) | int'(lfsr_q[0]);
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    check_cnt++;
    if (act_v !== exp_v) begin
      err_cnt++;
      $display("ERR %0t %s expected %h actual %h", $time, name, exp_v, act_v);
    end
  endtask

  // one access per cycle entered and left 2 ns after a rising edge
  task automatic bus_access(input logic write, input reg_addr_t addr, input reg_data_t wdata,
                            output reg_data_t rdata, output logic error);
    reg_valid = 1'b1;
    reg_write = write;
    reg_addr  = addr;
    reg_wdata = wdata;
    #1;
    rdata = reg_rdata;
    error = reg_error;
    @(posedge clk);
    #2;
    reg_valid = 1'b0;
    reg_write = 1'b0;
  endtask

  task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
    reg_data_t rdata;
    logic      error;
    bus_access(1'b1, addr, data, rdata, error);
    check_value($sformatf("reg_error_o@%h", addr), 32'h0, 32'(error));
  endtask

  task automatic read_expect(input reg_addr_t addr, input reg_data_t exp_v);
    reg_data_t rdata;
    logic      error;
    bus_access(1'b0, addr, '0, rdata, error);
    check_value($sformatf("reg_error_o@%h", addr), 32'h0, 32'(error));
    check_value($sformatf("reg_rdata_o@%h", addr), exp_v, rdata);
  endtask

  task automatic add_entry(input logic write, input reg_addr_t addr, input reg_data_t wdata,
                           input reg_data_t exp_rdata, input logic exp_error);
    table_q.push_back(access_t'{write, addr, wdata, exp_rdata, exp_error});
  endtask

  task automatic run_table();
    reg_data_t rdata;
    logic      error;
    foreach (table_q[i]) begin
      bus_access(table_q[i].write, table_q[i].addr, table_q[i].wdata, rdata, error);
      check_value($sformatf("reg_error_o@%h", table_q[i].addr),
                  32'(table_q[i].exp_error), 32'(error));
      if (!table_q[i].write) begin
        check_value($sformatf("reg_rdata_o@%h", table_q[i].addr), table_q[i].exp_rdata, rdata);
      end
    end
    table_q.delete();
  endtask

  task automatic wait_pwr_idle();
    reg_data_t status;
    logic      error;
    int        n;
    n = 0;
    bus_access(1'b0, PWR_STATUS_A, '0, status, error);
    while (status[PWR_BUSY_BIT] && n < 100) begin
      bus_access(1'b0, PWR_STATUS_A, '0, status, error);
      n++;
    end
    if (status[PWR_BUSY_BIT]) begin
      err_cnt++;
      $display("timeout: power switch still busy after 100 status polls");
    end
  endtask

  // each pulse at least 2 cycles high and 2 low plus a random extra gap
  task automatic drive_pulses(input int n);
    int gap;
    for (int i = 0; i < n; i++) begin
      gpio_in = 1'b1;
      gap = 2 + rand_bits(2);
      repeat (gap) @(posedge clk);
      #2;
      gpio_in = 1'b0;
      gap = 2 + rand_bits(2);
      repeat (gap) @(posedge clk);
      #2;
    end
    // synchronizer and edge detect drain
    repeat (4) @(posedge clk);
    #2;
  endtask

  initial begin
    int n;
    int na;
    int nb;
    reg_valid   = 1'b0;
    reg_write   = 1'b0;
    reg_addr    = '0;
    reg_wdata   = '0;
    gpio_in     = 1'b0;
    exp_pending = '0;
    lfsr_q      = 24'd92656;
    err_cnt     = 0;
    check_cnt   = 0;

    n = 0;
    while (rst_n !== 1'b1 && n < 100) begin
      @(posedge clk);
      n++;
    end
    if (rst_n !== 1'b1) begin
      err_cnt++;
      $display("timeout: reset never released");
    end
    @(posedge clk);
    #2;

    // values out of reset
    check_value("pwr_switch_n_o", 32'h0, 32'(pwr_switch_n));
    check_value("pwr_iso_n_o", 32'hF, 32'(pwr_iso_n));
    check_value("gpio_o", 32'h0, 32'(gpio_out));
    check_value("intr_vector_o", 32'h0, 32'(intr_vector));
    add_entry(1'b0, PWR_CTRL_A, '0, 32'h0, 1'b0);
    add_entry(1'b0, PWR_STATUS_A, '0, 32'h00F, 1'b0);
    add_entry(1'b0, CNT_MAX_A, '0, 32'd2048, 1'b0);
    add_entry(1'b0, INTR_PENDING_A, '0, 32'h0, 1'b0);
    add_entry(1'b0, INTR_ENABLE_A, '0, 32'h0, 1'b0);
    run_table();

    // error responses leave state untouched
    add_entry(1'b0, HOLE_A, '0, 32'h0, 1'b1);
    add_entry(1'b1, HOLE_A, 32'h5, 32'h0, 1'b1);
    add_entry(1'b0, PWR_CTRL_A + 32'h8, '0, 32'h0, 1'b1);
    add_entry(1'b1, PWR_CTRL_A + 32'h8, 32'h4, 32'h0, 1'b1);
    add_entry(1'b0, CNT_MAX_A + 32'hC, '0, 32'h0, 1'b1);
    add_entry(1'b1, CNT_MAX_A + 32'hC, 32'h3, 32'h0, 1'b1);
    add_entry(1'b0, INTR_PENDING_A + 32'h8, '0, 32'h0, 1'b1);
    add_entry(1'b1, INTR_PENDING_A + 32'h8, 32'h3, 32'h0, 1'b1);
    add_entry(1'b1, PWR_STATUS_A, 32'hF, 32'h0, 1'b1);
    add_entry(1'b1, CNT_VAL_A, 32'h7, 32'h0, 1'b1);
    add_entry(1'b1, CNT_MAX_A, 32'h0, 32'h0, 1'b1);
    add_entry(1'b0, CNT_MAX_A, '0, 32'd2048, 1'b0);
    add_entry(1'b0, CNT_VAL_A, '0, 32'h0, 1'b0);
    add_entry(1'b0, PWR_STATUS_A, '0, 32'h00F, 1'b0);
    add_entry(1'b0, PWR_CTRL_A, '0, 32'h0, 1'b0);
    add_entry(1'b0, INTR_PENDING_A, '0, 32'h0, 1'b0);
    add_entry(1'b0, INTR_ENABLE_A, '0, 32'h0, 1'b0);
    run_table();

    // domain 2 off and a second write rejected while busy
    add_entry(1'b1, PWR_CTRL_A, 32'h4, 32'h0, 1'b0);
    add_entry(1'b1, PWR_CTRL_A, 32'h0, 32'h0, 1'b1);
    add_entry(1'b0, PWR_CTRL_A, '0, 32'h4, 1'b0);
    add_entry(1'b0, PWR_STATUS_A, '0, 32'h10F, 1'b0);
    run_table();
    check_value("pwr_switch_n_o", 32'h4, 32'(pwr_switch_n));
    check_value("pwr_iso_n_o", 32'hB, 32'(pwr_iso_n));
    wait_pwr_idle();
    exp_pending[0] = 1'b1;
    read_expect(PWR_STATUS_A, 32'h00B);
    read_expect(INTR_PENDING_A, 32'(exp_pending));

    // domain 2 back on with isolation held until the ack returns
    write_reg(PWR_CTRL_A, 32'h0);
    check_value("pwr_switch_n_o", 32'h0, 32'(pwr_switch_n));
    check_value("pwr_iso_n_o", 32'hB, 32'(pwr_iso_n));
    wait_pwr_idle();
    check_value("pwr_iso_n_o", 32'hF, 32'(pwr_iso_n));
    read_expect(PWR_STATUS_A, 32'h00F);

    // counting below the limit without a wrap
    write_reg(CNT_MAX_A, 32'd5);
    read_expect(CNT_MAX_A, 32'd5);
    na = 1 + rand_bits(2);
    drive_pulses(na);
    read_expect(CNT_VAL_A, reg_data_t'(na));
    check_value("gpio_o", 32'h0, 32'(gpio_out));
    read_expect(INTR_PENDING_A, 32'(exp_pending));

    // limit rewrite restarts the count before at least one wrap
    write_reg(CNT_MAX_A, 32'd5);
    read_expect(CNT_VAL_A, 32'h0);
    nb = 6 + rand_bits(3);
    drive_pulses(nb);
    exp_pending[1] = 1'b1;
    read_expect(CNT_VAL_A, reg_data_t'(nb % 5));
    check_value("gpio_o", 32'((nb / 5) % 2), 32'(gpio_out));
    read_expect(INTR_PENDING_A, 32'(exp_pending));

    // vector is pending masked by enable
    for (int m = 0; m < 4; m++) begin
      write_reg(INTR_ENABLE_A, reg_data_t'(m));
      check_value("intr_vector_o", 32'(exp_pending & intr_vec_t'(m)), 32'(intr_vector));
      read_expect(INTR_ENABLE_A, reg_data_t'(m));
    end
    write_reg(INTR_PENDING_A, 32'h1);
    exp_pending[0] = 1'b0;
    check_value("intr_vector_o", 32'(exp_pending), 32'(intr_vector));
    write_reg(INTR_PENDING_A, 32'h2);
    exp_pending[1] = 1'b0;
    check_value("intr_vector_o", 32'(exp_pending), 32'(intr_vector));
    read_expect(INTR_PENDING_A, 32'h0);

    // rewriting the same switch value still ends in a done event
    write_reg(PWR_CTRL_A, 32'h0);
    wait_pwr_idle();
    exp_pending[0] = 1'b1;
    check_value("intr_vector_o", 32'(exp_pending), 32'(intr_vector));
    write_reg(INTR_PENDING_A, 32'h3);
    exp_pending = '0;
    check_value("intr_vector_o", 32'h0, 32'(intr_vector));

    $display("checks %0d, errors %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+.
reg_bus_pkg.sv
periph_pkg.sv
periph_reg_if.sv
periph_bus_decode.sv
pwr_switch_ctrl.sv
gpio_event_cnt.sv
intr_ctrl.sv
ext_periph_subsys.sv
tb_clk_gen.sv
ext_periph_properties.sv
tb_ext_periph_subsys.sv

// File: Makefile
SRCS := $(filter-out +%,$(shell cat compile.f)) subsys_cfg.svh

all: run

obj_dir/Vtb_ext_periph_subsys: compile.f $(SRCS)
	verilator --binary --timing --assert -f compile.f \
		--top-module tb_ext_periph_subsys -o Vtb_ext_periph_subsys

run: obj_dir/Vtb_ext_periph_subsys
	obj_dir/Vtb_ext_periph_subsys | tee sim.log
	@if grep -q "TB FAILED" sim.log; then exit 1; fi
	@grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
